//--- design/buffer_word_addr.sv
// word address counter for one pixel buffer, advancing per DMA beat with the RGB packing hold
`default_nettype none
`timescale 1ns/1ps

`include "pixel_rotate_settings.svh"

module buffer_word_addr
(
    input  wire                    I_CP_HCLK,
    input  wire                    I_CP_HRESET_N,
    input  wire                    enable,
    input  wire                    beat_take,
    input  wire [`ROT_COUNT_W-1:0] beat,
    input  wire                    tile_restart,
    output logic [`ROT_ADDR_W-1:0] word_addr
);

    logic [`ROT_ADDR_W-1:0] word_q;
    logic                   hold_word;
    logic [`ROT_ADDR_W-1:0] word_step;

    // 8 pixels = 24 bytes = 6 words, so two beats per row reuse a word
    // the skipped beats are the ones at column 5 and 6
    assign hold_word = (beat[2:0] == 3'd5) || (beat[2:0] == 3'd6);
    assign word_step = hold_word ? '0 : `ROT_ADDR_W'(1);

    // outside its own phase the counter reads as 0
    // first cycle of a new tile also starts from word 0
    always_comb
    begin
        if (enable && !tile_restart)
            word_addr = word_q;
        else
            word_addr = '0;
    end

    always_ff @(posedge I_CP_HCLK)
    begin
        if (!I_CP_HRESET_N)
        begin
            word_q <= '0;
        end
        else if (!enable)
        begin
            // idle or the other phase, also covers stop
            word_q <= '0;
        end
        else if (beat_take)
        begin
            word_q <= word_addr + word_step;
        end
        else
        begin
            word_q <= word_addr;
        end
    end

endmodule

`default_nettype wire

//--- design/pixel_rotate_core.sv
// top of the image rotation address engine, generates buffer addresses per DMA beat
`default_nettype none
`timescale 1ns/1ps

`include "pixel_rotate_settings.svh"

module pixel_rotate_core
(
    input  wire                          I_CP_HCLK,
    input  wire                          I_CP_HRESET_N,
    input  wire                          I_CP_DMA_READY,
    input  wire                          I_CP_STOP,
    input  wire                          I_CP_DIRECTION,
    input  wire [1:0]                    I_CP_DEGREES,
    output pixel_rotate_pkg::rot_phase_e phase,
    output logic [`ROT_ADDR_W-1:0]       in_word_addr,
    output logic [`ROT_ADDR_W-1:0]       out_word_addr,
    output logic [`ROT_ADDR_W-1:0]       rot_pixel_addr
);

    logic [`ROT_COUNT_W-1:0]      beat;
    logic                         tile_restart;
    logic                         read_en;
    logic                         write_en;
    logic [`ROT_ADDR_W-1:0]       map_addr;
    pixel_rotate_pkg::rot_angle_e angle;

    assign angle    = pixel_rotate_pkg::rot_angle_e'(I_CP_DEGREES);
    assign read_en  = (phase == pixel_rotate_pkg::PHASE_READ);
    assign write_en = (phase == pixel_rotate_pkg::PHASE_WRITE);

    // rotated address only matters while pixels move into the output buffer
    assign rot_pixel_addr = read_en ? map_addr : '0;

    tile_sequencer i_sequencer
    (
        .I_CP_HCLK     (I_CP_HCLK),
        .I_CP_HRESET_N (I_CP_HRESET_N),
        .dma_ready     (I_CP_DMA_READY),
        .stop          (I_CP_STOP),
        .phase         (phase),
        .beat          (beat),
        .tile_restart  (tile_restart)
    );

    rotate_addr_map i_rot_map
    (
        .beat           (beat),
        .degrees        (angle),
        .direction      (I_CP_DIRECTION),
        .rot_pixel_addr (map_addr)
    );

    // input buffer side, words fetched during read
    buffer_word_addr i_in_words
    (
        .I_CP_HCLK     (I_CP_HCLK),
        .I_CP_HRESET_N (I_CP_HRESET_N),
        .enable        (read_en),
        .beat_take     (I_CP_DMA_READY),
        .beat          (beat),
        .tile_restart  (tile_restart),
        .word_addr     (in_word_addr)
    );

    // output buffer side, words drained during write
    buffer_word_addr i_out_words
    (
        .I_CP_HCLK     (I_CP_HCLK),
        .I_CP_HRESET_N (I_CP_HRESET_N),
        .enable        (write_en),
        .beat_take     (I_CP_DMA_READY),
        .beat          (beat),
        .tile_restart  (tile_restart),
        .word_addr     (out_word_addr)
    );

endmodule

`default_nettype wire

//--- design/pixel_rotate_pkg.sv
// phase and rotation angle types shared by the rotation address engine, referenced by scoped name
`default_nettype none

package pixel_rotate_pkg;

    // engine phases
    // idle waits for the first DMA beat, then read and write alternate per tile
    typedef enum logic [1:0]
    {
        PHASE_IDLE  = 2'd0,
        PHASE_READ  = 2'd1,
        PHASE_WRITE = 2'd2
    } rot_phase_e;

    // rotation angle as driven on I_CP_DEGREES
    // the direction input picks ccw or cw for 90 and 270
    typedef enum logic [1:0]
    {
        DEG_0   = 2'd0,
        DEG_90  = 2'd1,
        DEG_180 = 2'd2,
        DEG_270 = 2'd3
    } rot_angle_e;

endpackage

`default_nettype wire

//--- design/pixel_rotate_settings.svh
// tile geometry and buffer address widths, included by the rotation engine RTL and testbench
`ifndef PIXEL_ROTATE_SETTINGS_SVH
`define PIXEL_ROTATE_SETTINGS_SVH

// pixels along one side of a square tile
`define ROT_TILE_SIDE 8

// pixels in one tile, one DMA beat each
`define ROT_TILE_PIXELS 64

// RGB, one byte per channel
`define ROT_BYTES_PER_PIXEL 3

// input and output buffers are 32 bits wide
`define ROT_WORD_BYTES 4

// byte and word addresses into either buffer
// a tile is 192 bytes, so 8 bits cover it
`define ROT_ADDR_W 8

// beat index within a phase, 0 to 63
`define ROT_COUNT_W 6

// G and B of a pixel sit at the red byte address plus one and plus two
// every 8 pixels fill 24 bytes, i.e. 6 buffer words

`endif

//--- design/rotate_addr_map.sv
// maps the beat index to the output-buffer byte address of the rotated pixel
`default_nettype none
`timescale 1ns/1ps

`include "pixel_rotate_settings.svh"

module rotate_addr_map
(
    input  wire [`ROT_COUNT_W-1:0]       beat,
    input  pixel_rotate_pkg::rot_angle_e degrees,
    input  wire                          direction,
    output logic [`ROT_ADDR_W-1:0]       rot_pixel_addr
);

    logic [2:0]              row;
    logic [2:0]              col;
    logic [`ROT_COUNT_W-1:0] idx_quarter_ccw;
    logic [`ROT_COUNT_W-1:0] idx_three_quarter_ccw;
    logic [`ROT_COUNT_W-1:0] idx_half;
    logic [`ROT_COUNT_W-1:0] pixel_idx;
    logic [`ROT_ADDR_W-1:0]  idx_times_two;

    // pixels arrive in raster order with 8 per row
    assign row = beat[`ROT_COUNT_W-1:3];
    assign col = beat[2:0];

    // ccw 90 puts source column c in row 7-c and source row r in column r
    assign idx_quarter_ccw = {3'(`ROT_TILE_SIDE - 1) - col, row};

    // ccw 270 puts source column c in row c and source row r in column 7-r
    assign idx_three_quarter_ccw = {col, 3'(`ROT_TILE_SIDE - 1) - row};

    // 180 walks the tile backwards as 63 - k
    assign idx_half = `ROT_COUNT_W'(`ROT_TILE_PIXELS - 1) - beat;

    always_comb
    begin
        case (degrees)
            pixel_rotate_pkg::DEG_0:
                pixel_idx = beat;
            pixel_rotate_pkg::DEG_90:
            begin
                // direction high is counter-clockwise
                if (direction)
                    pixel_idx = idx_quarter_ccw;
                else
                    pixel_idx = idx_three_quarter_ccw;
            end
            pixel_rotate_pkg::DEG_180:
                pixel_idx = idx_half;
            pixel_rotate_pkg::DEG_270:
            begin
                if (direction)
                    pixel_idx = idx_three_quarter_ccw;
                else
                    pixel_idx = idx_quarter_ccw;
            end
            default:
                pixel_idx = beat;
        endcase
    end

    // three bytes per pixel give index * 3 as a shift plus an add
    // largest address is 63 * 3 = 189 and fits in 8 bits
    assign idx_times_two  = `ROT_ADDR_W'(pixel_idx) << 1;
    assign rot_pixel_addr = idx_times_two + `ROT_ADDR_W'(pixel_idx);

endmodule

`default_nettype wire

//--- design/tile_sequencer.sv
// phase FSM and beat counter of the rotation engine, paced by DMA ready beats and stop
`default_nettype none
`timescale 1ns/1ps

`include "pixel_rotate_settings.svh"

module tile_sequencer
(
    input  wire                          I_CP_HCLK,
    input  wire                          I_CP_HRESET_N,
    input  wire                          dma_ready,
    input  wire                          stop,
    output pixel_rotate_pkg::rot_phase_e phase,
    output logic [`ROT_COUNT_W-1:0]      beat,
    output logic                         tile_restart
);

    logic                         beat_taken;
    logic                         last_beat;
    pixel_rotate_pkg::rot_phase_e phase_next;

    // no acknowledge on the DMA side, ready alone is the strobe
    assign beat_taken = dma_ready && !stop;
    assign last_beat  = (beat == `ROT_COUNT_W'(`ROT_TILE_PIXELS - 1));

    always_comb
    begin
        phase_next = phase;
        case (phase)
            pixel_rotate_pkg::PHASE_IDLE:
            begin
                // first beat only wakes the engine, read starts at beat 0
                if (beat_taken)
                    phase_next = pixel_rotate_pkg::PHASE_READ;
            end
            pixel_rotate_pkg::PHASE_READ:
            begin
                if (beat_taken && last_beat)
                    phase_next = pixel_rotate_pkg::PHASE_WRITE;
            end
            pixel_rotate_pkg::PHASE_WRITE:
            begin
                // next tile goes straight back to read
                if (beat_taken && last_beat)
                    phase_next = pixel_rotate_pkg::PHASE_READ;
            end
            default:
                phase_next = pixel_rotate_pkg::PHASE_IDLE;
        endcase
        // stop wins over any beat
        if (stop)
            phase_next = pixel_rotate_pkg::PHASE_IDLE;
    end

    always_ff @(posedge I_CP_HCLK)
    begin
        if (!I_CP_HRESET_N)
            phase <= pixel_rotate_pkg::PHASE_IDLE;
        else
            phase <= phase_next;
    end

    // beat index wraps 63 -> 0 together with the phase flip
    always_ff @(posedge I_CP_HCLK)
    begin
        if (!I_CP_HRESET_N)
            beat <= '0;
        else if (stop)
            beat <= '0;
        else if (beat_taken && (phase != pixel_rotate_pkg::PHASE_IDLE))
            beat <= beat + 1'b1;
    end

    // one cycle pulse at the start of every new read or write phase
    always_ff @(posedge I_CP_HCLK)
    begin
        if (!I_CP_HRESET_N)
            tile_restart <= 1'b0;
        else
            tile_restart <= beat_taken && last_beat &&
                            (phase != pixel_rotate_pkg::PHASE_IDLE);
    end

endmodule

`default_nettype wire

//--- dv/tb_checker.sv
// testbench checker that tracks phase and beat itself and compares every DUT output each cycle
`default_nettype none
`timescale 1ns/1ps

`include "pixel_rotate_settings.svh"

module tb_checker
(
    input  wire                          I_CP_HCLK,
    input  wire                          I_CP_HRESET_N,
    input  wire                          dma_ready,
    input  wire                          stop,
    input  wire                          direction,
    input  wire [1:0]                    degrees,
    input  pixel_rotate_pkg::rot_phase_e phase,
    input  wire [`ROT_ADDR_W-1:0]        in_word_addr,
    input  wire [`ROT_ADDR_W-1:0]        out_word_addr,
    input  wire [`ROT_ADDR_W-1:0]        rot_pixel_addr,
    input  wire [31:0]                   test_id,
    input  wire                          test_end,
    input  wire [31:0]                   last_addr_exp,
    output int                           error_count,
    output int                           check_count
);

    pixel_rotate_pkg::rot_phase_e phase_m;
    int                           beat_m;
    int                           errors_mark;
    int                           checks_mark;

    // words used before beat k, columns 5 and 6 share a word with their neighbour
    function automatic int word_index(input int k);
        int count;
        count = 0;
        for (int j = 0; j < k; j++)
        begin
            if ((j % 8 != 5) && (j % 8 != 6))
                count = count + 1;
        end
        return count;
    endfunction

    // pixel index after rotation, ccw high means counter-clockwise
    function automatic int rotated_index(input int k, input logic ccw, input logic [1:0] deg);
        int r;
        int c;
        int side;
        side = `ROT_TILE_SIDE;
        r    = k / side;
        c    = k % side;
        case (deg)
            2'd0:
                return k;
            2'd1:
                return ccw ? (side * (side - 1) - side * c + r) : (side * c + side - 1 - r);
            2'd2:
                return `ROT_TILE_PIXELS - 1 - k;
            default:
                return ccw ? (side * c + side - 1 - r) : (side * (side - 1) - side * c + r);
        endcase
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        check_count = check_count + 1;
        if (actual != expected)
        begin
            error_count = error_count + 1;
            $display("Fail at %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    // reference phase and beat, a beat counts when ready is high without stop
    always @(posedge I_CP_HCLK)
    begin
        if (!I_CP_HRESET_N || stop)
        begin
            phase_m <= pixel_rotate_pkg::PHASE_IDLE;
            beat_m  <= 0;
        end
        else if (dma_ready)
        begin
            if (phase_m == pixel_rotate_pkg::PHASE_IDLE)
                phase_m <= pixel_rotate_pkg::PHASE_READ;
            else if (beat_m == `ROT_TILE_PIXELS - 1)
            begin
                beat_m  <= 0;
                phase_m <= (phase_m == pixel_rotate_pkg::PHASE_READ) ?
                           pixel_rotate_pkg::PHASE_WRITE : pixel_rotate_pkg::PHASE_READ;
            end
            else
                beat_m <= beat_m + 1;
        end
    end

    // outputs settle well before the falling edge
    always @(negedge I_CP_HCLK)
    begin : compare_outputs
        logic reading;
        logic writing;
        reading = (phase_m == pixel_rotate_pkg::PHASE_READ);
        writing = (phase_m == pixel_rotate_pkg::PHASE_WRITE);
        if (!I_CP_HRESET_N)
        begin
            error_count = 0;
            check_count = 0;
        end
        else
        begin
            check_value("phase", int'(phase_m), int'(phase));
            check_value("in_word_addr", reading ? word_index(beat_m) : 0, int'(in_word_addr));
            check_value("out_word_addr", writing ? word_index(beat_m) : 0, int'(out_word_addr));
            check_value("rot_pixel_addr",
                        reading ? 3 * rotated_index(beat_m, direction, degrees) : 0,
                        int'(rot_pixel_addr));
            // last pixel of the tile against the table entry
            if (reading && (beat_m == `ROT_TILE_PIXELS - 1))
                check_value("rot_pixel_addr at beat 63", int'(last_addr_exp),
                            int'(rot_pixel_addr));
        end
    end

    always @(posedge I_CP_HCLK)
    begin
        if (!I_CP_HRESET_N)
        begin
            errors_mark <= 0;
            checks_mark <= 0;
        end
        else if (test_end)
        begin
            $display("test %0d (%s, %0d deg): %0d checks, %0d errors", test_id,
                     direction ? "ccw" : "cw", 90 * int'(degrees),
                     check_count - checks_mark, error_count - errors_mark);
            errors_mark <= error_count;
            checks_mark <= check_count;
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
// testbench clock and reset source, 100 ns clock period with reset held for the first 16 cycles
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen
(
    output logic I_CP_HCLK,
    output logic I_CP_HRESET_N
);

    initial
    begin
        I_CP_HCLK = 1'b0;
        forever
            #50 I_CP_HCLK = ~I_CP_HCLK;
    end

    // release lines up with the stimulus drive point after an edge
    initial
    begin
        I_CP_HRESET_N = 1'b0;
        repeat (16)
            @(posedge I_CP_HCLK);
        #10;
        I_CP_HRESET_N = 1'b1;
    end

endmodule

`default_nettype wire

//--- dv/tb_pixel_rotate.sv
// testbench top for the rotation address engine, drives the stimulus table through the DUT
`default_nettype none
`timescale 1ns/1ps

`include "pixel_rotate_settings.svh"

module tb_pixel_rotate;

    // last_addr is the rotated byte address expected at read beat 63
    // stop_after is the read beats taken before a stop, 0 for none
    typedef struct packed
    {
        logic       direction;
        logic [1:0] degrees;
        logic [3:0] tiles;
        logic       gaps;
        logic [6:0] stop_after;
        logic [7:0] last_addr;
    } test_row_t;

    localparam int NUM_TESTS = 12;

    localparam test_row_t TESTS [NUM_TESTS] = '{
        '{1'b1, 2'd0, 4'd1, 1'b0, 7'd0,  8'd189},
        '{1'b1, 2'd1, 4'd1, 1'b0, 7'd0,  8'd21},
        '{1'b1, 2'd2, 4'd1, 1'b0, 7'd0,  8'd0},
        '{1'b1, 2'd3, 4'd1, 1'b0, 7'd0,  8'd168},
        '{1'b0, 2'd0, 4'd1, 1'b0, 7'd0,  8'd189},
        '{1'b0, 2'd1, 4'd1, 1'b0, 7'd0,  8'd168},
        '{1'b0, 2'd2, 4'd1, 1'b0, 7'd0,  8'd0},
        '{1'b0, 2'd3, 4'd1, 1'b0, 7'd0,  8'd21},
        '{1'b1, 2'd1, 4'd2, 1'b1, 7'd0,  8'd21},
        '{1'b0, 2'd3, 4'd2, 1'b1, 7'd0,  8'd21},
        '{1'b1, 2'd2, 4'd1, 1'b0, 7'd20, 8'd0},
        '{1'b0, 2'd1, 4'd1, 1'b1, 7'd37, 8'd168}
    };

    logic                         I_CP_HCLK;
    logic                         I_CP_HRESET_N;
    logic                         dma_ready;
    logic                         stop;
    logic                         direction;
    logic [1:0]                   degrees;
    pixel_rotate_pkg::rot_phase_e phase;
    logic [`ROT_ADDR_W-1:0]       in_word_addr;
    logic [`ROT_ADDR_W-1:0]       out_word_addr;
    logic [`ROT_ADDR_W-1:0]       rot_pixel_addr;
    logic [31:0]                  test_id;
    logic                         test_end;
    logic [31:0]                  last_addr_exp;
    int                           error_count;
    int                           check_count;
    logic [31:0]                  lfsr_state;

    tb_clock_gen i_clock
    (
        .I_CP_HCLK     (I_CP_HCLK),
        .I_CP_HRESET_N (I_CP_HRESET_N)
    );

    pixel_rotate_core i_dut
    (
        .I_CP_HCLK      (I_CP_HCLK),
        .I_CP_HRESET_N  (I_CP_HRESET_N),
        .I_CP_DMA_READY (dma_ready),
        .I_CP_STOP      (stop),
        .I_CP_DIRECTION (direction),
        .I_CP_DEGREES   (degrees),
        .phase          (phase),
        .in_word_addr   (in_word_addr),
        .out_word_addr  (out_word_addr),
        .rot_pixel_addr (rot_pixel_addr)
    );

    tb_checker i_checker
    (
        .I_CP_HCLK      (I_CP_HCLK),
        .I_CP_HRESET_N  (I_CP_HRESET_N),
        .dma_ready      (dma_ready),
        .stop           (stop),
        .direction      (direction),
        .degrees        (degrees),
        .phase          (phase),
        .in_word_addr   (in_word_addr),
        .out_word_addr  (out_word_addr),
        .rot_pixel_addr (rot_pixel_addr),
        .test_id        (test_id),
        .test_end       (test_end),
        .last_addr_exp  (last_addr_exp),
        .error_count    (error_count),
        .check_count    (check_count)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic random_bit(output logic b);
        lfsr_state = lfsr_next(lfsr_state);
        b = lfsr_state[0];
    endtask

    function automatic int table_beats();
        int total;
        total = 16;
        for (int i = 0; i < NUM_TESTS; i++)
            total = total + int'(TESTS[i].tiles) * 128 + int'(TESTS[i].stop_after) + 12;
        return total;
    endfunction

    task automatic drive_cycle(input logic ready, input logic stop_in);
        @(posedge I_CP_HCLK);
        #10;
        dma_ready = ready;
        stop      = stop_in;
    endtask

    task automatic wait_for_phase(input pixel_rotate_pkg::rot_phase_e target);
        while (phase != target)
            drive_cycle(1'b0, 1'b0);
    endtask

    // random idle cycles ahead of each beat when gaps are on
    task automatic take_beats(input int count, input logic gaps);
        logic idle;
        for (int n = 0; n < count; n++)
        begin
            idle = 1'b0;
            if (gaps)
                random_bit(idle);
            while (idle)
            begin
                drive_cycle(1'b0, 1'b0);
                random_bit(idle);
            end
            drive_cycle(1'b1, 1'b0);
        end
    endtask

    task automatic run_test(input int idx);
        test_row_t row;
        row = TESTS[idx];
        @(posedge I_CP_HCLK);
        #10;
        test_id       = idx;
        last_addr_exp = 32'(row.last_addr);
        direction     = row.direction;
        degrees       = row.degrees;
        dma_ready     = 1'b0;
        stop          = 1'b0;
        if (row.stop_after != 7'd0)
        begin
            drive_cycle(1'b1, 1'b0);
            wait_for_phase(pixel_rotate_pkg::PHASE_READ);
            take_beats(int'(row.stop_after), row.gaps);
            // stop with ready still high, stop has to win
            drive_cycle(1'b1, 1'b1);
            wait_for_phase(pixel_rotate_pkg::PHASE_IDLE);
        end
        drive_cycle(1'b1, 1'b0);
        wait_for_phase(pixel_rotate_pkg::PHASE_READ);
        take_beats(int'(row.tiles) * 2 * `ROT_TILE_PIXELS, row.gaps);
        drive_cycle(1'b0, 1'b1);
        wait_for_phase(pixel_rotate_pkg::PHASE_IDLE);
        @(posedge I_CP_HCLK);
        #10;
        test_end = 1'b1;
        @(posedge I_CP_HCLK);
        #10;
        test_end = 1'b0;
    endtask

    initial
    begin
        dma_ready     = 1'b0;
        stop          = 1'b0;
        direction     = 1'b0;
        degrees       = 2'd0;
        test_id       = '0;
        test_end      = 1'b0;
        last_addr_exp = '0;
        lfsr_state    = 32'ha6bd84fb;
        wait (I_CP_HRESET_N);
        // engine left alone for a while after reset
        repeat (4)
            drive_cycle(1'b0, 1'b0);
        for (int i = 0; i < NUM_TESTS; i++)
            run_test(i);
        repeat (2)
            drive_cycle(1'b0, 1'b0);
        $display("summary: %0d tests, %0d checks, %0d errors",
                 NUM_TESTS, check_count, error_count);
        if ((error_count == 0) && (check_count > 0))
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    initial
    begin : watchdog
        int limit_ns;
        limit_ns = table_beats() * 4 * 100;
        #(limit_ns);
        $display("watchdog expired after %0d ns, the engine did not get through the table",
                 limit_ns);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line in its output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f sources.f \
    --top-module tb_pixel_rotate -o sim_pixel_rotate || exit 1

out=$(./obj_dir/sim_pixel_rotate)
echo "$out"

echo "$out" | grep -q "^Simulation completed successfully$" && echo "run passed" \
    || { echo "run did not pass"; exit 1; }

//--- sources.f
+incdir+design
design/pixel_rotate_pkg.sv
design/tile_sequencer.sv
design/rotate_addr_map.sv
design/buffer_word_addr.sv
design/pixel_rotate_core.sv
dv/tb_clock_gen.sv
dv/tb_checker.sv
dv/tb_pixel_rotate.sv
